//--- verilog.f
+incdir+include
hdl/udp_tx_pkg.sv
hdl/udp_tx_fifo.sv
hdl/udp_checksum_engine.sv
hdl/udp_tx_sequencer.sv
hdl/udp_tx_top.sv
verif/udp_tx_assertions.sv
verif/udp_tx_tb.sv

//--- verif/udp_tx_tb.sv
// UDP transmit testbench
// table of frames written into the DUT, an IP/MAC responder that collects
// the streamed bytes, and a reference checksum model

`timescale 1ns/10ps
`include "udp_tx_params.svh"

module udp_tx_tb;

  import udp_tx_pkg::*;

  localparam int NUM_FRAMES  = 8;
  localparam int MAX_BYTES   = 128;
  localparam int TIMEOUT     = 2000;
  localparam int BURST_FIRST = 5;

  // expected total counts header and zero padding
  typedef struct packed {
    udp_endpoint_t ep;
    udp_len_t      len;
    udp_len_t      total;
  } frame_row_t;

  localparam udp_endpoint_t EP_A = {32'hC0A8_010A, 32'hC0A8_0114, 16'd5000, 16'd6000};
  localparam udp_endpoint_t EP_B = {32'hFFFF_FFFE, 32'hFFFF_0001, 16'hFFFF, 16'hFFF0};
  localparam udp_endpoint_t EP_C = {32'h0A00_0001, 32'h0A00_00FE, 16'h0035, 16'hC351};
  localparam udp_endpoint_t EP_D = {32'hAC10_2001, 32'hAC10_2002, 16'h1234, 16'h4321};
  localparam udp_endpoint_t EP_E = {32'h7F00_0001, 32'hE000_00FB, 16'h14E9, 16'h14E9};

  logic          clk;
  logic          rst_n;
  udp_endpoint_t endpoint;
  logic          frame_start;
  udp_len_t      payload_len;
  logic          wr_en;
  udp_byte_t     wr_data;
  logic          ip_tx_ack;
  logic          udp_data_req;
  logic          mac_send_end;
  logic          frame_ready;
  logic          almost_full;
  logic          ip_tx_req;
  logic          tx_ready;
  logic          tx_valid;
  logic          tx_last;
  udp_byte_t     tx_data;

  frame_row_t rows [NUM_FRAMES];
  string      names [NUM_FRAMES];
  udp_byte_t  pay_buf [1024];
  udp_byte_t  exp_mem [NUM_FRAMES][MAX_BYTES];
  udp_byte_t  rx_mem [NUM_FRAMES][MAX_BYTES];
  udp_len_t   exp_cks [NUM_FRAMES];
  int         rx_len [NUM_FRAMES];
  int         rx_count;
  int         frames_written;
  int         errors;
  int         tests_run;
  int         tests_failed;
  logic       aborted;

  udp_tx_top dut (.*);

  initial clk = 1'b0;

  always #10 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // compare and report helpers
  ////////////////////////////////////////////////////////////

  task automatic check_byte(input string what, input udp_byte_t exp, input udp_byte_t act);
    if (exp !== act)
    begin
      errors++;
      $display("mismatch %s: expected 0x%02h, actual 0x%02h", what, exp, act);
    end
  endtask

  task automatic check_len(input string what, input udp_len_t exp, input udp_len_t act);
    if (exp !== act)
    begin
      errors++;
      $display("mismatch %s: expected 0x%04h, actual 0x%04h", what, exp, act);
    end
  endtask

  task automatic check_flag(input string what, input logic exp, input logic act);
    if (exp !== act)
    begin
      errors++;
      $display("mismatch %s: expected %b, actual %b", what, exp, act);
    end
  endtask

  task automatic note_failure(input string why);
    errors++;
    aborted = 1'b1;
    $display("error: %s", why);
  endtask

  task automatic finish_test(input string name, input int err0);
    tests_run++;
    if (errors != err0)
    begin
      tests_failed++;
      $display("%s: failed with %0d errors", name, errors - err0);
    end
    else
      $display("%s: ok", name);
  endtask

  task automatic load_table();
    rows[0]  = {EP_A, 16'd40, 16'd48};
    names[0] = "len40";
    rows[1]  = {EP_B, 16'd100, 16'd108};
    names[1] = "len100";
    rows[2]  = {EP_C, 16'd33, 16'd41};
    names[2] = "odd33";
    rows[3]  = {EP_D, 16'd0, 16'd26};
    names[3] = "len0";
    rows[4]  = {EP_D, 16'd10, 16'd26};
    names[4] = "len10";
    // three frames queued before the first one is sent
    rows[5]  = {EP_E, 16'd20, 16'd28};
    names[5] = "burst_a";
    rows[6]  = {EP_E, 16'd57, 16'd65};
    names[6] = "burst_b";
    rows[7]  = {EP_E, 16'd64, 16'd72};
    names[7] = "burst_c";
  endtask

  ////////////////////////////////////////////////////////////
  // reference model and frame writer
  ////////////////////////////////////////////////////////////

  // pseudo-header, header and payload words, carries folded until none left
  function automatic udp_len_t ref_checksum(input udp_endpoint_t ep, input int len);
    logic [31:0] sum;
    udp_len_t    ulen;
    int          i;
    ulen = udp_len_t'(len + `UDP_HDR_LEN);
    sum  = ep.src_ip[31:16] + ep.src_ip[15:0] + ep.dst_ip[31:16] + ep.dst_ip[15:0];
    sum  = sum + `UDP_PROTO + ep.src_port + ep.dst_port + ulen + ulen;
    for (i = 0; i < len; i += 2)
    begin
      if (i + 1 < len)
        sum = sum + {pay_buf[i], pay_buf[i + 1]};
      else
        sum = sum + {pay_buf[i], 8'h00};
    end
    while (sum[31:16] != 16'h0)
      sum = sum[15:0] + sum[31:16];
    return ~sum[15:0];
  endfunction

  task automatic prepare_frame(input int f);
    int       i;
    int       len;
    udp_len_t ulen;
    len  = int'(rows[f].len);
    ulen = rows[f].len + udp_len_t'(`UDP_HDR_LEN);
    for (i = 0; i < len; i++)
      pay_buf[i] = udp_byte_t'($urandom);
    exp_cks[f] = ref_checksum(rows[f].ep, len);
    for (i = 0; i < MAX_BYTES; i++)
      exp_mem[f][i] = 8'h00;
    exp_mem[f][0] = rows[f].ep.src_port[15:8];
    exp_mem[f][1] = rows[f].ep.src_port[7:0];
    exp_mem[f][2] = rows[f].ep.dst_port[15:8];
    exp_mem[f][3] = rows[f].ep.dst_port[7:0];
    exp_mem[f][4] = ulen[15:8];
    exp_mem[f][5] = ulen[7:0];
    exp_mem[f][6] = exp_cks[f][15:8];
    exp_mem[f][7] = exp_cks[f][7:0];
    for (i = 0; i < len; i++)
      exp_mem[f][`UDP_HDR_LEN + i] = pay_buf[i];
  endtask

  task automatic write_frame(input int f);
    int i;
    int n;
    n = 0;
    while (frame_ready !== 1'b1 && !aborted && n < TIMEOUT)
    begin
      @(posedge clk);
      #2;
      n++;
    end
    if (frame_ready !== 1'b1)
    begin
      note_failure($sformatf("%s: frame_ready never came back high", names[f]));
      return;
    end
    frame_start = 1'b1;
    payload_len = rows[f].len;
    @(posedge clk);
    #2;
    frame_start = 1'b0;
    for (i = 0; i < int'(rows[f].len); i++)
    begin
      n = 0;
      while (almost_full !== 1'b0 && !aborted && n < TIMEOUT)
      begin
        @(posedge clk);
        #2;
        n++;
      end
      if (almost_full !== 1'b0)
      begin
        note_failure($sformatf("%s: payload FIFO stayed almost full", names[f]));
        return;
      end
      wr_en   = 1'b1;
      wr_data = pay_buf[i];
      @(posedge clk);
      #2;
      wr_en = 1'b0;
    end
    frames_written++;
  endtask

  task automatic wait_sent(input int count);
    int n;
    n = 0;
    while (rx_count < count && !aborted && n < TIMEOUT)
    begin
      @(posedge clk);
      #2;
      n++;
    end
    if (rx_count < count)
      note_failure($sformatf("only %0d of %0d frames were sent", rx_count, count));
  endtask

  task automatic check_frame(input int f);
    int i;
    int err0;
    err0 = errors;
    check_len({names[f], " length"}, rows[f].total, udp_len_t'(rx_len[f]));
    check_len({names[f], " checksum"}, exp_cks[f], {rx_mem[f][6], rx_mem[f][7]});
    for (i = 0; i < rx_len[f] && i < int'(rows[f].total); i++)
      check_byte($sformatf("%s byte %0d", names[f], i), exp_mem[f][i], rx_mem[f][i]);
    finish_test(names[f], err0);
  endtask

  ////////////////////////////////////////////////////////////
  // IP and MAC responder
  ////////////////////////////////////////////////////////////

  initial
  begin : responder
    int f;
    int n;
    int k;
    for (f = 0; f < NUM_FRAMES; f++)
    begin
      n = 0;
      while (ip_tx_req !== 1'b1 && !aborted && n < TIMEOUT)
      begin
        @(posedge clk);
        #2;
        n++;
      end
      if (ip_tx_req !== 1'b1)
      begin
        note_failure($sformatf("no IP request for frame %0d", f));
        disable responder;
      end
      // first burst frame waits until the whole burst is in the DUT
      if (f == BURST_FIRST)
      begin
        n = 0;
        while (frames_written < NUM_FRAMES && !aborted && n < TIMEOUT)
        begin
          @(posedge clk);
          #2;
          n++;
        end
        if (frames_written < NUM_FRAMES)
        begin
          note_failure("burst frames were not all written");
          disable responder;
        end
      end
      // ack after a short random delay
      repeat (1 + $urandom % 3) @(posedge clk);
      #2;
      ip_tx_ack = 1'b1;
      @(posedge clk);
      #2;
      ip_tx_ack = 1'b0;
      n = 0;
      while (tx_ready !== 1'b1 && !aborted && n < TIMEOUT)
      begin
        @(posedge clk);
        #2;
        n++;
      end
      if (tx_ready !== 1'b1)
      begin
        note_failure($sformatf("tx_ready never raised for frame %0d", f));
        disable responder;
      end
      repeat (1 + $urandom % 3) @(posedge clk);
      #2;
      udp_data_req = 1'b1;
      @(posedge clk);
      #2;
      udp_data_req = 1'b0;
      // first byte is due right after the data request
      k = 0;
      while (k < MAX_BYTES)
      begin
        if (tx_valid !== 1'b1)
        begin
          note_failure($sformatf("frame %0d: tx_valid low at byte %0d", f, k));
          disable responder;
        end
        rx_mem[f][k] = tx_data;
        k++;
        if (tx_last === 1'b1)
          break;
        @(posedge clk);
        #2;
      end
      rx_len[f] = k;
      @(posedge clk);
      #2;
      mac_send_end = 1'b1;
      @(posedge clk);
      #2;
      mac_send_end = 1'b0;
      check_frame(f);
      rx_count++;
    end
  end

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial
  begin
    int f;
    int i;
    int err0;
    void'($urandom(64247));
    rst_n          = 1'b0;
    endpoint       = '0;
    frame_start    = 1'b0;
    payload_len    = '0;
    wr_en          = 1'b0;
    wr_data        = '0;
    ip_tx_ack      = 1'b0;
    udp_data_req   = 1'b0;
    mac_send_end   = 1'b0;
    rx_count       = 0;
    frames_written = 0;
    errors         = 0;
    tests_run      = 0;
    tests_failed   = 0;
    aborted        = 1'b0;
    load_table();
    repeat (8) @(posedge clk);
    #2;
    rst_n = 1'b1;
    // idle outputs with nothing queued
    err0 = errors;
    for (i = 0; i < 4; i++)
    begin
      @(posedge clk);
      #2;
      check_flag("after_reset ip_tx_req", 1'b0, ip_tx_req);
      check_flag("after_reset tx_ready", 1'b0, tx_ready);
      check_flag("after_reset tx_valid", 1'b0, tx_valid);
      check_flag("after_reset frame_ready", 1'b1, frame_ready);
      check_flag("after_reset almost_full", 1'b0, almost_full);
    end
    finish_test("after_reset", err0);
    for (f = 0; f < NUM_FRAMES && !aborted; f++)
    begin
      // endpoint must stay put until all frames using it are out
      if (rows[f].ep != endpoint)
      begin
        wait_sent(f);
        endpoint = rows[f].ep;
      end
      prepare_frame(f);
      write_frame(f);
    end
    wait_sent(NUM_FRAMES);
    errors += dut.u_tx_sequencer.u_assertions.fail_count;
    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0 && !aborted)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule

//--- verif/udp_tx_assertions.sv
// UDP transmit sequencer protocol assertions
// IP request hold, ready/valid exclusion and gapless byte streaming

`timescale 1ns/10ps

module udp_tx_assertions (
  input logic clk,
  input logic rst_n,
  input logic ip_tx_req,
  input logic ip_tx_ack,
  input logic tx_ready,
  input logic tx_valid,
  input logic tx_last
);

  int fail_count = 0;

  // request stays up until the IP layer acknowledges
  property req_held_until_ack;
    @(posedge clk) disable iff (!rst_n)
      ip_tx_req && !ip_tx_ack |=> ip_tx_req;
  endproperty

  // and drops in the cycle after the ack
  property req_drops_after_ack;
    @(posedge clk) disable iff (!rst_n)
      ip_tx_req && ip_tx_ack |=> !ip_tx_req;
  endproperty

  property ready_valid_exclusive;
    @(posedge clk) disable iff (!rst_n)
      !(tx_ready && tx_valid);
  endproperty

  // no gaps between first byte and tx_last
  property valid_until_last;
    @(posedge clk) disable iff (!rst_n)
      tx_valid && !tx_last |=> tx_valid;
  endproperty

  a_req_held: assert property (req_held_until_ack)
  else
  begin
    fail_count++;
    $error("ip_tx_req dropped before ip_tx_ack");
  end

  a_req_drop: assert property (req_drops_after_ack)
  else
  begin
    fail_count++;
    $error("ip_tx_req still high after ip_tx_ack");
  end

  a_ready_valid: assert property (ready_valid_exclusive)
  else
  begin
    fail_count++;
    $error("tx_ready and tx_valid high together");
  end

  a_valid_run: assert property (valid_until_last)
  else
  begin
    fail_count++;
    $error("tx_valid dropped before tx_last");
  end

endmodule

bind udp_tx_sequencer udp_tx_assertions u_assertions (
  .clk       (clk),
  .rst_n     (rst_n),
  .ip_tx_req (ip_tx_req),
  .ip_tx_ack (ip_tx_ack),
  .tx_ready  (tx_ready),
  .tx_valid  (tx_valid),
  .tx_last   (tx_last)
);

//--- hdl/udp_tx_top.sv
// UDP transmit top level
// payload FIFO and checksum engine on the write side, descriptor FIFO
// between the engine and the transmit sequencer

`timescale 1ns/10ps
`include "udp_tx_params.svh"

module udp_tx_top (
  input  logic                      clk,
  input  logic                      rst_n,
  input  udp_tx_pkg::udp_endpoint_t endpoint,
  input  logic                      frame_start,
  input  udp_tx_pkg::udp_len_t      payload_len,
  input  logic                      wr_en,
  input  udp_tx_pkg::udp_byte_t     wr_data,
  input  logic                      ip_tx_ack,
  input  logic                      udp_data_req,
  input  logic                      mac_send_end,
  output logic                      frame_ready,
  output logic                      almost_full,
  output logic                      ip_tx_req,
  output logic                      tx_ready,
  output logic                      tx_valid,
  output logic                      tx_last,
  output udp_tx_pkg::udp_byte_t     tx_data
);

  import udp_tx_pkg::*;

  udp_desc_t desc;
  udp_desc_t desc_head;
  logic      desc_push;
  logic      desc_pop;
  logic      desc_empty;
  udp_byte_t pay_head;
  logic      pay_pop;

  // payload bytes, written by the user and drained by the sequencer
  udp_tx_fifo #(
    .DW ($bits(udp_byte_t)),
    .AW (`PAYLOAD_FIFO_AW)
  ) u_payload_fifo (
    .clk         (clk),
    .rst_n       (rst_n),
    .push        (wr_en),
    .push_data   (wr_data),
    .pop         (pay_pop),
    .head        (pay_head),
    .empty       (),
    .full        (),
    .almost_full (almost_full)
  );

  udp_checksum_engine u_checksum_engine (
    .clk         (clk),
    .rst_n       (rst_n),
    .endpoint    (endpoint),
    .frame_start (frame_start),
    .payload_len (payload_len),
    .wr_en       (wr_en),
    .wr_data     (wr_data),
    .frame_ready (frame_ready),
    .desc_push   (desc_push),
    .desc        (desc)
  );

  // length and checksum per queued frame
  udp_tx_fifo #(
    .DW ($bits(udp_desc_t)),
    .AW (`DESC_FIFO_AW)
  ) u_desc_fifo (
    .clk         (clk),
    .rst_n       (rst_n),
    .push        (desc_push),
    .push_data   (desc),
    .pop         (desc_pop),
    .head        (desc_head),
    .empty       (desc_empty),
    .full        (),
    .almost_full ()
  );

  udp_tx_sequencer u_tx_sequencer (
    .clk          (clk),
    .rst_n        (rst_n),
    .endpoint     (endpoint),
    .desc_head    (desc_head),
    .desc_empty   (desc_empty),
    .pay_head     (pay_head),
    .ip_tx_ack    (ip_tx_ack),
    .udp_data_req (udp_data_req),
    .mac_send_end (mac_send_end),
    .desc_pop     (desc_pop),
    .pay_pop      (pay_pop),
    .ip_tx_req    (ip_tx_req),
    .tx_ready     (tx_ready),
    .tx_valid     (tx_valid),
    .tx_last      (tx_last),
    .tx_data      (tx_data)
  );

endmodule

//--- hdl/udp_tx_sequencer.sv
// UDP transmit sequencer
// takes one descriptor at a time, runs the IP and MAC handshakes and
// streams header, payload and zero padding

`timescale 1ns/10ps
`include "udp_tx_params.svh"

module udp_tx_sequencer (
  input  logic                      clk,
  input  logic                      rst_n,
  input  udp_tx_pkg::udp_endpoint_t endpoint,
  input  udp_tx_pkg::udp_desc_t     desc_head,
  input  logic                      desc_empty,
  input  udp_tx_pkg::udp_byte_t     pay_head,
  input  logic                      ip_tx_ack,
  input  logic                      udp_data_req,
  input  logic                      mac_send_end,
  output logic                      desc_pop,
  output logic                      pay_pop,
  output logic                      ip_tx_req,
  output logic                      tx_ready,
  output logic                      tx_valid,
  output logic                      tx_last,
  output udp_tx_pkg::udp_byte_t     tx_data
);

  import udp_tx_pkg::*;

  seq_state_e state;
  udp_desc_t  cur_desc;
  udp_len_t   total;
  udp_len_t   cnt;
  logic       desc_take;
  logic       in_payload;

  assign desc_take = (state == SEQ_IDLE) && !desc_empty;
  assign desc_pop  = desc_take;

  // current frame, with its streamed length padded to the minimum
  always_ff @(posedge clk)
  begin
    if (desc_take)
    begin
      cur_desc <= desc_head;
      if (desc_head.udp_len < udp_len_t'(`UDP_MIN_LEN))
        total <= udp_len_t'(`UDP_MIN_LEN);
      else
        total <= desc_head.udp_len;
    end
  end

  ////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state <= SEQ_IDLE;
      cnt   <= '0;
    end
    else
    begin
      // byte index only runs during the send
      if (state == SEQ_SEND)
        cnt <= cnt + 1'b1;
      else
        cnt <= '0;
      case (state)
        SEQ_IDLE:
        begin
          if (desc_take)
            state <= SEQ_IP_REQ;
        end
        SEQ_IP_REQ:
        begin
          if (ip_tx_ack)
            state <= SEQ_READY;
        end
        SEQ_READY:
        begin
          if (udp_data_req)
            state <= SEQ_SEND;
        end
        SEQ_SEND:
        begin
          if (tx_last)
            state <= SEQ_END;
        end
        SEQ_END:
        begin
          if (mac_send_end)
            state <= SEQ_IDLE;
        end
        default:
          state <= SEQ_IDLE;
      endcase
    end
  end

  assign ip_tx_req = (state == SEQ_IP_REQ);
  assign tx_ready  = (state == SEQ_READY);
  assign tx_valid  = (state == SEQ_SEND);
  assign tx_last   = tx_valid && (cnt == total - udp_len_t'(1));

  ////////////////////////////////////////////////////////////
  // output byte select
  ////////////////////////////////////////////////////////////

  assign in_payload = (cnt >= udp_len_t'(`UDP_HDR_LEN)) && (cnt < cur_desc.udp_len);
  assign pay_pop    = tx_valid && in_payload;

  always_comb
  begin
    tx_data = '0;
    if (tx_valid)
    begin
      case (cnt)
        16'd0: tx_data = endpoint.src_port[15:8];
        16'd1: tx_data = endpoint.src_port[7:0];
        16'd2: tx_data = endpoint.dst_port[15:8];
        16'd3: tx_data = endpoint.dst_port[7:0];
        16'd4: tx_data = cur_desc.udp_len[15:8];
        16'd5: tx_data = cur_desc.udp_len[7:0];
        16'd6: tx_data = cur_desc.checksum[15:8];
        16'd7: tx_data = cur_desc.checksum[7:0];
        default:
        begin
          // padding past udp_len stays zero
          if (in_payload)
            tx_data = pay_head;
        end
      endcase
    end
  end

endmodule

//--- hdl/udp_checksum_engine.sv
// UDP checksum engine
// sums pseudo-header, UDP header and payload words as the bytes are written,
// folds the carries and pushes one length/checksum descriptor per frame

`timescale 1ns/10ps
`include "udp_tx_params.svh"

module udp_checksum_engine (
  input  logic                      clk,
  input  logic                      rst_n,
  input  udp_tx_pkg::udp_endpoint_t endpoint,
  input  logic                      frame_start,
  input  udp_tx_pkg::udp_len_t      payload_len,
  input  logic                      wr_en,
  input  udp_tx_pkg::udp_byte_t     wr_data,
  output logic                      frame_ready,
  output logic                      desc_push,
  output udp_tx_pkg::udp_desc_t     desc
);

  import udp_tx_pkg::*;

  ck_state_e   state;
  udp_len_t    udp_len;
  udp_len_t    remain;
  udp_byte_t   hi_byte;
  logic        hi_valid;
  logic        fold_second;
  logic [31:0] acc;
  logic [31:0] hdr_sum;
  logic [31:0] acc_add;
  udp_len_t    word;
  logic        word_add;
  logic        byte_take;
  logic        last_byte;

  ////////////////////////////////////////////////////////////
  // word assembly
  ////////////////////////////////////////////////////////////

  // bytes may already arrive while the header is being summed
  assign byte_take = wr_en && (remain != '0)
                     && (state == CK_HEADER || state == CK_PAYLOAD);
  assign last_byte = byte_take && (remain == udp_len_t'(1));

  // big-endian pairs, an odd tail byte gets a zero low byte
  assign word     = hi_valid ? {hi_byte, wr_data} : {wr_data, 8'h00};
  assign word_add = byte_take && (hi_valid || last_byte);

  // pseudo-header plus UDP header, length counted twice
  assign hdr_sum = 32'(endpoint.src_ip[31:16]) + 32'(endpoint.src_ip[15:0])
                 + 32'(endpoint.dst_ip[31:16]) + 32'(endpoint.dst_ip[15:0])
                 + 32'(`UDP_PROTO)
                 + 32'(endpoint.src_port) + 32'(endpoint.dst_port)
                 + 32'(udp_len) + 32'(udp_len);

  assign acc_add = ((state == CK_HEADER) ? hdr_sum : 32'd0)
                 + (word_add ? 32'(word) : 32'd0);

  ////////////////////////////////////////////////////////////
  // control
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state       <= CK_IDLE;
      remain      <= '0;
      hi_valid    <= 1'b0;
      fold_second <= 1'b0;
    end
    else
    begin
      if (byte_take)
      begin
        remain   <= remain - 1'b1;
        hi_valid <= !hi_valid;
      end
      case (state)
        CK_IDLE:
        begin
          if (frame_start)
          begin
            state    <= CK_HEADER;
            remain   <= payload_len;
            hi_valid <= 1'b0;
          end
        end
        CK_HEADER:
        begin
          // empty payload or a single byte already taken
          if (remain == '0 || last_byte)
            state <= CK_FOLD;
          else
            state <= CK_PAYLOAD;
        end
        CK_PAYLOAD:
        begin
          if (last_byte)
            state <= CK_FOLD;
        end
        CK_FOLD:
        begin
          // two passes, flag ends up cleared again
          fold_second <= !fold_second;
          if (fold_second)
            state <= CK_PUSH;
        end
        CK_PUSH:
          state <= CK_IDLE;
        default:
          state <= CK_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // datapath
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (state == CK_IDLE && frame_start)
    begin
      udp_len <= payload_len + udp_len_t'(`UDP_HDR_LEN);
      acc     <= '0;
    end
    else if (state == CK_HEADER || state == CK_PAYLOAD)
    begin
      acc <= acc + acc_add;
    end
    else if (state == CK_FOLD)
    begin
      acc <= 32'(acc[15:0]) + 32'(acc[31:16]);
    end
    if (byte_take && !hi_valid)
    begin
      hi_byte <= wr_data;
    end
  end

  assign frame_ready   = (state == CK_IDLE);
  assign desc_push     = (state == CK_PUSH);
  assign desc.udp_len  = udp_len;
  // plain ones' complement, zero is sent as is
  assign desc.checksum = ~acc[15:0];

endmodule

//--- hdl/udp_tx_fifo.sv
// Synchronous FIFO with show-ahead head output
// used for payload bytes and for frame descriptors

`timescale 1ns/10ps

module udp_tx_fifo #(
  parameter int DW = 8,
  parameter int AW = 10
) (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          push,
  input  logic [DW-1:0] push_data,
  input  logic          pop,
  output logic [DW-1:0] head,
  output logic          empty,
  output logic          full,
  output logic          almost_full
);

  localparam int DEPTH = 1 << AW;
  localparam logic [AW:0] DEPTH_W = (AW+1)'(DEPTH);

  logic [DW-1:0] mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   count;
  logic          do_push;
  logic          do_pop;

  // overflow and underflow attempts are dropped
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  always_ff @(posedge clk)
  begin
    if (do_push)
    begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_push)
      begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop)
      begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // oldest entry, visible before the pop
  assign head = mem[rd_ptr];

  assign empty       = (count == '0);
  assign full        = (count == DEPTH_W);
  // fewer than 4 free slots
  assign almost_full = ((DEPTH_W - count) < (AW+1)'(4));

endmodule

//--- hdl/udp_tx_pkg.sv
// UDP transmit shared types
// data, length, endpoint and descriptor types plus the FSM state encodings

package udp_tx_pkg;

  // one payload or header byte
  typedef logic [7:0] udp_byte_t;

  // byte counts and 16-bit checksum words
  typedef logic [15:0] udp_len_t;

  // addressing of the current frame, held by the user while it is in flight
  typedef struct packed {
    logic [31:0] src_ip;
    logic [31:0] dst_ip;
    logic [15:0] src_port;
    logic [15:0] dst_port;
  } udp_endpoint_t;

  // one entry per frame, from checksum engine to sequencer
  typedef struct packed {
    udp_len_t udp_len;
    udp_len_t checksum;
  } udp_desc_t;

  // checksum engine
  typedef enum logic [2:0] {
    CK_IDLE,
    CK_HEADER,
    CK_PAYLOAD,
    CK_FOLD,
    CK_PUSH
  } ck_state_e;

  // transmit sequencer
  typedef enum logic [2:0] {
    SEQ_IDLE,
    SEQ_IP_REQ,
    SEQ_READY,
    SEQ_SEND,
    SEQ_END
  } seq_state_e;

endpackage

//--- include/udp_tx_params.svh
// UDP transmit constants
// frame lengths, IP protocol number and FIFO sizing

`ifndef UDP_TX_PARAMS_SVH
`define UDP_TX_PARAMS_SVH

////////////////////////////////////////////////////////////
// frame format
////////////////////////////////////////////////////////////

// source port, destination port, length, checksum
`define UDP_HDR_LEN 8

// shorter frames are zero padded up to this many bytes
`define UDP_MIN_LEN 26

`define UDP_PROTO 17

////////////////////////////////////////////////////////////
// buffering
////////////////////////////////////////////////////////////

// 1024 payload bytes, also the largest payload per frame
`define PAYLOAD_FIFO_AW 10
// up to 4 frames waiting for the sequencer
`define DESC_FIFO_AW 2

`endif
